/* common/ctl_pkg.sv */
package ctl_pkg;

    // tag pool size
    // also sets the list entries and table rows
    localparam int CTL_LIST_DEPTH = 8;

    // tag width, at least log2 of the depth
    localparam int CTL_LIST_WIDTH = 3;

    // command payload
    localparam int CMD_ADDR_WIDTH = 16;

    // reset fill for list contents
    // INCR loads tags 0 to depth-1 in order
    localparam string INIT_INCR = "INCR";
    localparam string INIT_ZERO = "ZERO";

    // reset state for list valid bits
    localparam string INIT_VALID = "VALID";
    localparam string INIT_EMPTY = "EMPTY";

endpackage

/* ctl_list/ctl_list.sv */
`timescale 1ns/1ps

module ctl_list #(
    parameter string init_value_type = ctl_pkg::INIT_INCR,
    parameter string init_valid      = ctl_pkg::INIT_VALID
) (
    input  logic                                ctl_clk,
    input  logic                                ctl_reset_n,
    input  logic                                list_get,
    input  logic                                list_put,
    input  logic [ctl_pkg::CTL_LIST_WIDTH-1:0]  list_put_entry_id,
    output logic                                list_get_entry_valid,
    output logic [ctl_pkg::CTL_LIST_WIDTH-1:0]  list_get_entry_id,
    output logic [ctl_pkg::CTL_LIST_DEPTH-1:0]  list_get_entry_id_vector,
    output logic                                list_put_entry_ready
);

    // entry 0 is the head
    logic [ctl_pkg::CTL_LIST_WIDTH-1:0] list_q [ctl_pkg::CTL_LIST_DEPTH];
    logic [ctl_pkg::CTL_LIST_DEPTH-1:0] valid_q;
    logic [ctl_pkg::CTL_LIST_DEPTH-1:0] vector_q;

    // contents after the get shift
    logic [ctl_pkg::CTL_LIST_WIDTH-1:0] shift_list [ctl_pkg::CTL_LIST_DEPTH];
    logic [ctl_pkg::CTL_LIST_DEPTH-1:0] shift_valid;

    // contents after the put
    logic [ctl_pkg::CTL_LIST_WIDTH-1:0] list_d [ctl_pkg::CTL_LIST_DEPTH];
    logic [ctl_pkg::CTL_LIST_DEPTH-1:0] valid_d;
    logic [ctl_pkg::CTL_LIST_DEPTH-1:0] vector_d;

    assign list_get_entry_valid     = valid_q[0];
    assign list_get_entry_id        = list_q[0];
    assign list_get_entry_id_vector = vector_q;
    // room left while the tail slot is empty
    assign list_put_entry_ready     = ~valid_q[ctl_pkg::CTL_LIST_DEPTH-1];

    // get moves every entry one step toward the head
    always_comb
    begin
        shift_list  = list_q;
        shift_valid = valid_q;
        if (list_get)
        begin
            for (int i = 1; i < ctl_pkg::CTL_LIST_DEPTH; i++)
            begin
                shift_list[i-1]  = list_q[i];
                shift_valid[i-1] = valid_q[i];
            end
            shift_valid[ctl_pkg::CTL_LIST_DEPTH-1] = 1'b0;
        end
    end

    // put fills the first empty slot of the shifted list
    // on a same-cycle get this is the slot just vacated
    always_comb
    begin
        list_d  = shift_list;
        valid_d = shift_valid;
        if (list_put)
        begin
            if (~shift_valid[0])
            begin
                list_d[0]  = list_put_entry_id;
                valid_d[0] = 1'b1;
            end
            for (int i = 1; i < ctl_pkg::CTL_LIST_DEPTH; i++)
            begin
                if (shift_valid[i-1] & ~shift_valid[i])
                begin
                    list_d[i]  = list_put_entry_id;
                    valid_d[i] = 1'b1;
                end
            end
        end
        // one-hot of the new head, all zero when empty
        for (int i = 0; i < ctl_pkg::CTL_LIST_DEPTH; i++)
        begin
            vector_d[i] = valid_d[0] & (list_d[0] == i[ctl_pkg::CTL_LIST_WIDTH-1:0]);
        end
    end

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (~ctl_reset_n)
        begin
            for (int i = 0; i < ctl_pkg::CTL_LIST_DEPTH; i++)
            begin
                if (init_value_type == ctl_pkg::INIT_INCR)
                begin
                    list_q[i] <= i[ctl_pkg::CTL_LIST_WIDTH-1:0];
                end
                else
                begin
                    list_q[i] <= '0;
                end
            end
            if (init_valid == ctl_pkg::INIT_VALID)
            begin
                valid_q  <= '1;
                // both fills hold tag 0 at the head
                vector_q <= {{(ctl_pkg::CTL_LIST_DEPTH-1){1'b0}}, 1'b1};
            end
            else
            begin
                valid_q  <= '0;
                vector_q <= '0;
            end
        end
        else
        begin
            list_q   <= list_d;
            valid_q  <= valid_d;
            vector_q <= vector_d;
        end
    end

endmodule

/* verilog/cmd_accept.sv */
`timescale 1ns/1ps

module cmd_accept (
    input  logic                                ctl_clk,
    input  logic                                ctl_reset_n,
    input  logic                                in_req,
    input  logic [ctl_pkg::CMD_ADDR_WIDTH-1:0]  in_addr,
    input  logic                                in_write,
    input  logic                                free_valid,
    input  logic [ctl_pkg::CTL_LIST_WIDTH-1:0]  free_id,
    output logic                                in_ack,
    output logic                                alloc,
    output logic [ctl_pkg::CTL_LIST_WIDTH-1:0]  alloc_id,
    output logic [ctl_pkg::CMD_ADDR_WIDTH-1:0]  alloc_addr,
    output logic                                alloc_write
);

    typedef enum logic {
        ACC_IDLE,
        ACC_ACK
    } acc_state_t;

    acc_state_t state;

    // take a command only when a tag is free
    assign alloc       = (state == ACC_IDLE) & in_req & free_valid;
    // tag comes from the free list head
    assign alloc_id    = free_id;
    assign alloc_addr  = in_addr;
    assign alloc_write = in_write;

    assign in_ack = (state == ACC_ACK);

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (~ctl_reset_n)
        begin
            state <= ACC_IDLE;
        end
        else
        begin
            case (state)
                ACC_IDLE:
                begin
                    if (alloc)
                    begin
                        state <= ACC_ACK;
                    end
                end
                default:
                begin
                    // hold ack until the requester lets go
                    if (~in_req)
                    begin
                        state <= ACC_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* verilog/cmd_issue.sv */
`timescale 1ns/1ps

module cmd_issue (
    input  logic                                ctl_clk,
    input  logic                                ctl_reset_n,
    input  logic                                head_valid,
    input  logic [ctl_pkg::CTL_LIST_WIDTH-1:0]  head_id,
    input  logic [ctl_pkg::CMD_ADDR_WIDTH-1:0]  head_addr,
    input  logic                                head_write,
    input  logic                                out_ack,
    output logic                                out_req,
    output logic [ctl_pkg::CTL_LIST_WIDTH-1:0]  out_id,
    output logic [ctl_pkg::CMD_ADDR_WIDTH-1:0]  out_addr,
    output logic                                out_write,
    output logic                                release_tag
);

    typedef enum logic [1:0] {
        ISS_IDLE,
        ISS_REQ,
        ISS_WAIT_LOW
    } iss_state_t;

    iss_state_t state;

    assign out_req = (state == ISS_REQ);

    // memory side has the command, so drop it from pending and free the tag
    assign release_tag = (state == ISS_REQ) & out_ack;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (~ctl_reset_n)
        begin
            state <= ISS_IDLE;
        end
        else
        begin
            case (state)
                ISS_IDLE:
                begin
                    if (head_valid)
                    begin
                        state <= ISS_REQ;
                    end
                end
                ISS_REQ:
                begin
                    if (out_ack)
                    begin
                        state <= ISS_WAIT_LOW;
                    end
                end
                default:
                begin
                    if (~out_ack)
                    begin
                        state <= ISS_IDLE;
                    end
                end
            endcase
        end
    end

    // payload held stable for the whole request
    always_ff @(posedge ctl_clk)
    begin
        if ((state == ISS_IDLE) & head_valid)
        begin
            out_id    <= head_id;
            out_addr  <= head_addr;
            out_write <= head_write;
        end
    end

endmodule

/* verilog/cmd_table.sv */
`timescale 1ns/1ps

module cmd_table (
    input  logic                                ctl_clk,
    input  logic                                ctl_reset_n,
    input  logic                                wr_en,
    input  logic [ctl_pkg::CTL_LIST_WIDTH-1:0]  wr_id,
    input  logic [ctl_pkg::CMD_ADDR_WIDTH-1:0]  wr_addr,
    input  logic                                wr_write,
    input  logic [ctl_pkg::CTL_LIST_DEPTH-1:0]  rd_sel,
    output logic [ctl_pkg::CMD_ADDR_WIDTH-1:0]  rd_addr,
    output logic                                rd_write
);

    // one row per tag
    logic [ctl_pkg::CMD_ADDR_WIDTH-1:0] row_addr [ctl_pkg::CTL_LIST_DEPTH];
    logic [ctl_pkg::CTL_LIST_DEPTH-1:0] row_write;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (~ctl_reset_n)
        begin
            for (int i = 0; i < ctl_pkg::CTL_LIST_DEPTH; i++)
            begin
                row_addr[i] <= '0;
            end
            row_write <= '0;
        end
        else if (wr_en)
        begin
            row_addr[wr_id]  <= wr_addr;
            row_write[wr_id] <= wr_write;
        end
    end

    // and-or mux on the one-hot select
    always_comb
    begin
        rd_addr  = '0;
        rd_write = 1'b0;
        for (int i = 0; i < ctl_pkg::CTL_LIST_DEPTH; i++)
        begin
            rd_addr  = rd_addr | (row_addr[i] & {ctl_pkg::CMD_ADDR_WIDTH{rd_sel[i]}});
            rd_write = rd_write | (row_write[i] & rd_sel[i]);
        end
    end

endmodule

/* verilog/cmd_tracker.sv */
`timescale 1ns/1ps

module cmd_tracker (
    input  logic                                ctl_clk,
    input  logic                                ctl_reset_n,
    input  logic                                in_req,
    input  logic [ctl_pkg::CMD_ADDR_WIDTH-1:0]  in_addr,
    input  logic                                in_write,
    input  logic                                out_ack,
    output logic                                in_ack,
    output logic                                out_req,
    output logic [ctl_pkg::CTL_LIST_WIDTH-1:0]  out_id,
    output logic [ctl_pkg::CMD_ADDR_WIDTH-1:0]  out_addr,
    output logic                                out_write
);

    // free tag pool head
    logic                               free_valid;
    logic [ctl_pkg::CTL_LIST_WIDTH-1:0] free_id;

    // pending queue head
    logic                               pend_valid;
    logic [ctl_pkg::CTL_LIST_WIDTH-1:0] pend_id;
    logic [ctl_pkg::CTL_LIST_DEPTH-1:0] pend_vector;

    // accepted command
    logic                               alloc;
    logic [ctl_pkg::CTL_LIST_WIDTH-1:0] alloc_id;
    logic [ctl_pkg::CMD_ADDR_WIDTH-1:0] alloc_addr;
    logic                               alloc_write;

    // payload of the pending head
    logic [ctl_pkg::CMD_ADDR_WIDTH-1:0] head_addr;
    logic                               head_write;

    logic                               release_tag;

    // starts full, ready and pending vector not needed here
    ctl_list #(
        .init_value_type (ctl_pkg::INIT_INCR),
        .init_valid      (ctl_pkg::INIT_VALID)
    ) free_list_i (
        .ctl_clk                  (ctl_clk),
        .ctl_reset_n              (ctl_reset_n),
        .list_get                 (alloc),
        .list_put                 (release_tag),
        .list_put_entry_id        (out_id),
        .list_get_entry_valid     (free_valid),
        .list_get_entry_id        (free_id),
        .list_get_entry_id_vector (),
        .list_put_entry_ready     ()
    );

    // in-order queue of tags waiting to issue
    ctl_list #(
        .init_value_type (ctl_pkg::INIT_ZERO),
        .init_valid      (ctl_pkg::INIT_EMPTY)
    ) pend_list_i (
        .ctl_clk                  (ctl_clk),
        .ctl_reset_n              (ctl_reset_n),
        .list_get                 (release_tag),
        .list_put                 (alloc),
        .list_put_entry_id        (alloc_id),
        .list_get_entry_valid     (pend_valid),
        .list_get_entry_id        (pend_id),
        .list_get_entry_id_vector (pend_vector),
        .list_put_entry_ready     ()
    );

    cmd_table cmd_table_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .wr_en       (alloc),
        .wr_id       (alloc_id),
        .wr_addr     (alloc_addr),
        .wr_write    (alloc_write),
        .rd_sel      (pend_vector),
        .rd_addr     (head_addr),
        .rd_write    (head_write)
    );

    cmd_accept cmd_accept_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .in_req      (in_req),
        .in_addr     (in_addr),
        .in_write    (in_write),
        .free_valid  (free_valid),
        .free_id     (free_id),
        .in_ack      (in_ack),
        .alloc       (alloc),
        .alloc_id    (alloc_id),
        .alloc_addr  (alloc_addr),
        .alloc_write (alloc_write)
    );

    cmd_issue cmd_issue_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .head_valid  (pend_valid),
        .head_id     (pend_id),
        .head_addr   (head_addr),
        .head_write  (head_write),
        .out_ack     (out_ack),
        .out_req     (out_req),
        .out_id      (out_id),
        .out_addr    (out_addr),
        .out_write   (out_write),
        .release_tag (release_tag)
    );

endmodule

/* verification/cmd_tracker_tb.sv */
`timescale 1ns/1ps

module cmd_tracker_tb;

    localparam int ROWS      = 24;
    localparam int MAX_DELAY = 60;

    logic                               ctl_clk;
    logic                               ctl_reset_n;
    logic                               in_req;
    logic [ctl_pkg::CMD_ADDR_WIDTH-1:0] in_addr;
    logic                               in_write;
    logic                               out_ack;
    logic                               in_ack;
    logic                               out_req;
    logic [ctl_pkg::CTL_LIST_WIDTH-1:0] out_id;
    logic [ctl_pkg::CMD_ADDR_WIDTH-1:0] out_addr;
    logic                               out_write;

    // stimulus and expected values, one row per command
    logic [ctl_pkg::CMD_ADDR_WIDTH-1:0] row_addr [ROWS];
    logic                               row_write [ROWS];
    int                                 row_delay [ROWS];
    int                                 exp_id [ROWS];

    integer seed;
    int     error_count;
    int     tests_run;
    int     tests_failed;
    int     protocol_errors;
    int     bp_errors;
    int     blocked_cycles;
    int     accepted;
    int     issued;
    int     released;
    logic   prev_in_req;
    logic   prev_in_ack;
    logic   prev_out_req;
    logic   prev_out_ack;
    int     err_start;

    cmd_tracker dut_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .in_req      (in_req),
        .in_addr     (in_addr),
        .in_write    (in_write),
        .out_ack     (out_ack),
        .in_ack      (in_ack),
        .out_req     (out_req),
        .out_id      (out_id),
        .out_addr    (out_addr),
        .out_write   (out_write)
    );

    initial
    begin
        ctl_clk = 1'b0;
        forever #10 ctl_clk = ~ctl_clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input bit failed);
        tests_run++;
        if (failed)
        begin
            tests_failed++;
        end
        $display("%s: %s", name, failed ? "fail" : "pass");
    endtask

    task automatic fill_table();
        logic [31:0] rnd;
        for (int n = 0; n < ROWS; n++)
        begin
            rnd          = $random(seed);
            row_addr[n]  = rnd[ctl_pkg::CMD_ADDR_WIDTH-1:0];
            row_write[n] = rnd[31];
            // two slow rows stall the memory side long enough to fill the tracker
            row_delay[n] = (n == 4 || n == 15) ? MAX_DELAY : n % 3;
            // tags come back in issue order, so they cycle through the pool
            exp_id[n]    = n % ctl_pkg::CTL_LIST_DEPTH;
        end
    endtask

    // requester side, one four-phase handshake per row
    task automatic drive_requests();
        for (int n = 0; n < ROWS; n++)
        begin
            @(posedge ctl_clk);
            in_req   <= 1'b1;
            in_addr  <= row_addr[n];
            in_write <= row_write[n];
            @(posedge ctl_clk);
            while (!in_ack)
                @(posedge ctl_clk);
            in_req <= 1'b0;
            @(posedge ctl_clk);
            while (in_ack)
                @(posedge ctl_clk);
        end
    endtask

    // memory side, acks each command after its row delay
    task automatic answer_requests();
        int row_err;
        for (int n = 0; n < ROWS; n++)
        begin
            row_err = error_count;
            @(posedge ctl_clk);
            while (!out_req)
                @(posedge ctl_clk);
            check_value("out_addr", 32'(out_addr), 32'(row_addr[n]));
            check_value("out_write", 32'(out_write), 32'(row_write[n]));
            check_value("out_id", 32'(out_id), 32'(exp_id[n]));
            repeat (row_delay[n]) @(posedge ctl_clk);
            out_ack <= 1'b1;
            @(posedge ctl_clk);
            while (out_req)
                @(posedge ctl_clk);
            out_ack <= 1'b0;
            report_test($sformatf("row %0d addr 0x%h write %b id %0d", n, row_addr[n],
                                  row_write[n], exp_id[n]), error_count != row_err);
        end
    endtask

    // protocol and occupancy monitor on sampled port values
    always @(posedge ctl_clk)
    begin
        if (!ctl_reset_n)
        begin
            accepted = 0;
            issued   = 0;
            released = 0;
        end
        else
        begin
            if (in_ack && !prev_in_ack)
            begin
                if (!prev_in_req)
                begin
                    $display("at %0t ns: in_ack rose while in_req was low", $time);
                    error_count++;
                    protocol_errors++;
                end
                if (accepted - released >= ctl_pkg::CTL_LIST_DEPTH)
                begin
                    $display("at %0t ns: in_ack rose with all tags in flight", $time);
                    error_count++;
                    bp_errors++;
                end
                accepted++;
            end
            if (out_req && !prev_out_req)
            begin
                if (prev_out_ack)
                begin
                    $display("at %0t ns: out_req rose while out_ack was high", $time);
                    error_count++;
                    protocol_errors++;
                end
                if (issued >= accepted)
                begin
                    $display("at %0t ns: out_req rose with no accepted command", $time);
                    error_count++;
                    protocol_errors++;
                end
                issued++;
            end
            if (!out_req && prev_out_req)
            begin
                if (!prev_out_ack)
                begin
                    $display("at %0t ns: out_req fell before out_ack rose", $time);
                    error_count++;
                    protocol_errors++;
                end
                released++;
            end
            // tracker full and a request waiting
            if (in_req && !in_ack && (accepted - released == ctl_pkg::CTL_LIST_DEPTH))
            begin
                blocked_cycles++;
            end
        end
        prev_in_req  <= in_req;
        prev_in_ack  <= in_ack;
        prev_out_req <= out_req;
        prev_out_ack <= out_ack;
    end

    initial
    begin
        repeat (ROWS * (MAX_DELAY + 10)) @(posedge ctl_clk);
        $display("timeout: the handshakes did not complete in time");
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        seed            = 32'h8a3dfe3a;
        error_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        protocol_errors = 0;
        bp_errors       = 0;
        blocked_cycles  = 0;
        ctl_reset_n    <= 1'b0;
        in_req         <= 1'b0;
        in_addr        <= '0;
        in_write       <= 1'b0;
        out_ack        <= 1'b0;
        fill_table();
        repeat (2) @(posedge ctl_clk);
        ctl_reset_n <= 1'b1;

        err_start = error_count;
        repeat (3)
        begin
            @(posedge ctl_clk);
            check_value("in_ack", 32'(in_ack), 32'd0);
            check_value("out_req", 32'(out_req), 32'd0);
        end
        report_test("reset state", error_count != err_start);

        fork
            drive_requests();
            answer_requests();
        join
        repeat (2) @(posedge ctl_clk);

        err_start = error_count;
        check_value("accepted", 32'(accepted), 32'(ROWS));
        check_value("released", 32'(released), 32'(ROWS));
        if (blocked_cycles == 0)
        begin
            $display("back-pressure was never reached, the tracker never filled up");
            error_count++;
        end
        report_test($sformatf("back-pressure (%0d blocked cycles)", blocked_cycles),
                    bp_errors != 0 || error_count != err_start);
        report_test("handshake protocol", protocol_errors != 0);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* cmd_tracker.f */
common/ctl_pkg.sv
ctl_list/ctl_list.sv
verilog/cmd_accept.sv
verilog/cmd_issue.sv
verilog/cmd_table.sv
verilog/cmd_tracker.sv
verification/cmd_tracker_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module cmd_tracker_tb \
    -f cmd_tracker.f -o cmd_tracker_sim

./obj_dir/cmd_tracker_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
